// ==== logic/rv_core_pkg.sv ====
// RV64 integer pipeline definitions
package rv_core_pkg;

    typedef logic [63:0] xlen_t;
    typedef logic [31:0] instr_t;
    typedef logic [4:0]  reg_addr_t;

    // major opcodes
    localparam logic [6:0] OPC_LUI       = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC     = 7'b0010111;
    localparam logic [6:0] OPC_JAL       = 7'b1101111;
    localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_OP        = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
    localparam logic [6:0] OPC_OP_32     = 7'b0111011;

    // funct3, shared by register and immediate forms
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // funct7, upper six bits also used for 64-bit shift immediates
    localparam logic [6:0] F7_NORMAL  = 7'b0000000;
    localparam logic [6:0] F7_SUB_SRA = 7'b0100000;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } alu_op_e;

    // privileged spec mcause codes
    typedef enum logic [3:0] {
        EXC_INSTR_MISALIGNED = 4'd0,
        EXC_ILLEGAL_INSTR    = 4'd2
    } exc_cause_e;

    // link value for jal is pc plus one instruction
    localparam xlen_t LINK_OFFSET = 64'd4;

endpackage

// ==== logic/imm_gen.sv ====
// Immediate generator
module imm_gen (
    input  rv_core_pkg::instr_t instr_i,
    output rv_core_pkg::xlen_t  imm_o
);

    logic [6:0] opcode;

    assign opcode = instr_i[6:0];

    always_comb begin
        case (opcode)
            // I format
            rv_core_pkg::OPC_OP_IMM,
            rv_core_pkg::OPC_OP_IMM_32: begin
                imm_o = {{52{instr_i[31]}}, instr_i[31:20]};
            end
            // U format
            rv_core_pkg::OPC_LUI,
            rv_core_pkg::OPC_AUIPC: begin
                imm_o = {{32{instr_i[31]}}, instr_i[31:12], 12'b0};
            end
            // J format, bit 0 always zero
            rv_core_pkg::OPC_JAL: begin
                imm_o = {{43{instr_i[31]}}, instr_i[31], instr_i[19:12],
                         instr_i[20], instr_i[30:21], 1'b0};
            end
            default: begin
                imm_o = '0;
            end
        endcase
    end

endmodule

// ==== logic/decode_stage.sv ====
// Instruction decode stage
module decode_stage (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   valid_i,
    input  rv_core_pkg::instr_t    instr_i,
    input  rv_core_pkg::xlen_t     pc_i,
    input  rv_core_pkg::xlen_t     rs1_data_i,
    input  rv_core_pkg::xlen_t     rs2_data_i,
    output logic                   valid_o,
    output rv_core_pkg::alu_op_e   alu_op_o,
    output logic                   op_32_o,
    output rv_core_pkg::xlen_t     op_a_o,
    output rv_core_pkg::xlen_t     op_b_o,
    output rv_core_pkg::reg_addr_t rd_o,
    output logic                   jump_o,
    output rv_core_pkg::xlen_t     jump_addr_o,
    output logic                   illegal_o,
    output logic                   misaligned_o
);

    rv_core_pkg::xlen_t   imm;
    rv_core_pkg::alu_op_e alu_op;
    rv_core_pkg::xlen_t   op_a;
    rv_core_pkg::xlen_t   op_b;
    rv_core_pkg::xlen_t   jump_addr;
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       op_32;
    logic       use_imm;
    logic       use_pc;
    logic       zero_a;
    logic       is_jal;
    logic       illegal;

    imm_gen imm_gen_inst (
        .instr_i(instr_i),
        .imm_o  (imm)
    );

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    always_comb begin
        alu_op  = rv_core_pkg::ALU_ADD;
        op_32   = 1'b0;
        use_imm = 1'b0;
        use_pc  = 1'b0;
        zero_a  = 1'b0;
        is_jal  = 1'b0;
        illegal = 1'b0;

        case (opcode)
            rv_core_pkg::OPC_LUI: begin
                use_imm = 1'b1;
                zero_a  = 1'b1;
            end
            rv_core_pkg::OPC_AUIPC: begin
                use_imm = 1'b1;
                use_pc  = 1'b1;
            end
            // link value goes through the alu, target is computed here
            rv_core_pkg::OPC_JAL: begin
                use_pc = 1'b1;
                is_jal = 1'b1;
            end
            rv_core_pkg::OPC_OP_IMM: begin
                use_imm = 1'b1;
                case (funct3)
                    rv_core_pkg::F3_ADD_SUB: alu_op = rv_core_pkg::ALU_ADD;
                    rv_core_pkg::F3_SLT:     alu_op = rv_core_pkg::ALU_SLT;
                    rv_core_pkg::F3_SLTU:    alu_op = rv_core_pkg::ALU_SLTU;
                    rv_core_pkg::F3_XOR:     alu_op = rv_core_pkg::ALU_XOR;
                    rv_core_pkg::F3_OR:      alu_op = rv_core_pkg::ALU_OR;
                    rv_core_pkg::F3_AND:     alu_op = rv_core_pkg::ALU_AND;
                    rv_core_pkg::F3_SLL: begin
                        alu_op  = rv_core_pkg::ALU_SLL;
                        // shamt is 6 bits, only funct7[6:1] checked
                        illegal = (funct7[6:1] != rv_core_pkg::F7_NORMAL[6:1]);
                    end
                    default: begin
                        if (funct7[6:1] == rv_core_pkg::F7_SUB_SRA[6:1]) begin
                            alu_op = rv_core_pkg::ALU_SRA;
                        end else if (funct7[6:1] == rv_core_pkg::F7_NORMAL[6:1]) begin
                            alu_op = rv_core_pkg::ALU_SRL;
                        end else begin
                            illegal = 1'b1;
                        end
                    end
                endcase
            end
            rv_core_pkg::OPC_OP: begin
                case ({funct7, funct3})
                    {rv_core_pkg::F7_NORMAL,  rv_core_pkg::F3_ADD_SUB}: alu_op = rv_core_pkg::ALU_ADD;
                    {rv_core_pkg::F7_SUB_SRA, rv_core_pkg::F3_ADD_SUB}: alu_op = rv_core_pkg::ALU_SUB;
                    {rv_core_pkg::F7_NORMAL,  rv_core_pkg::F3_SLL}:     alu_op = rv_core_pkg::ALU_SLL;
                    {rv_core_pkg::F7_NORMAL,  rv_core_pkg::F3_SLT}:     alu_op = rv_core_pkg::ALU_SLT;
                    {rv_core_pkg::F7_NORMAL,  rv_core_pkg::F3_SLTU}:    alu_op = rv_core_pkg::ALU_SLTU;
                    {rv_core_pkg::F7_NORMAL,  rv_core_pkg::F3_XOR}:     alu_op = rv_core_pkg::ALU_XOR;
                    {rv_core_pkg::F7_NORMAL,  rv_core_pkg::F3_SRL_SRA}: alu_op = rv_core_pkg::ALU_SRL;
                    {rv_core_pkg::F7_SUB_SRA, rv_core_pkg::F3_SRL_SRA}: alu_op = rv_core_pkg::ALU_SRA;
                    {rv_core_pkg::F7_NORMAL,  rv_core_pkg::F3_OR}:      alu_op = rv_core_pkg::ALU_OR;
                    {rv_core_pkg::F7_NORMAL,  rv_core_pkg::F3_AND}:     alu_op = rv_core_pkg::ALU_AND;
                    default: illegal = 1'b1;
                endcase
            end
            rv_core_pkg::OPC_OP_IMM_32: begin
                use_imm = 1'b1;
                op_32   = 1'b1;
                case (funct3)
                    rv_core_pkg::F3_ADD_SUB: alu_op = rv_core_pkg::ALU_ADD;
                    rv_core_pkg::F3_SLL: begin
                        alu_op  = rv_core_pkg::ALU_SLL;
                        illegal = (funct7 != rv_core_pkg::F7_NORMAL);
                    end
                    rv_core_pkg::F3_SRL_SRA: begin
                        if (funct7 == rv_core_pkg::F7_SUB_SRA) begin
                            alu_op = rv_core_pkg::ALU_SRA;
                        end else if (funct7 == rv_core_pkg::F7_NORMAL) begin
                            alu_op = rv_core_pkg::ALU_SRL;
                        end else begin
                            illegal = 1'b1;
                        end
                    end
                    default: illegal = 1'b1;
                endcase
            end
            rv_core_pkg::OPC_OP_32: begin
                op_32 = 1'b1;
                case ({funct7, funct3})
                    {rv_core_pkg::F7_NORMAL,  rv_core_pkg::F3_ADD_SUB}: alu_op = rv_core_pkg::ALU_ADD;
                    {rv_core_pkg::F7_SUB_SRA, rv_core_pkg::F3_ADD_SUB}: alu_op = rv_core_pkg::ALU_SUB;
                    {rv_core_pkg::F7_NORMAL,  rv_core_pkg::F3_SLL}:     alu_op = rv_core_pkg::ALU_SLL;
                    {rv_core_pkg::F7_NORMAL,  rv_core_pkg::F3_SRL_SRA}: alu_op = rv_core_pkg::ALU_SRL;
                    {rv_core_pkg::F7_SUB_SRA, rv_core_pkg::F3_SRL_SRA}: alu_op = rv_core_pkg::ALU_SRA;
                    default: illegal = 1'b1;
                endcase
            end
            default: begin
                illegal = 1'b1;
            end
        endcase
    end

    // operand muxes
    assign op_a = zero_a ? '0 : (use_pc ? pc_i : rs1_data_i);
    assign op_b = is_jal ? rv_core_pkg::LINK_OFFSET : (use_imm ? imm : rs2_data_i);

    assign jump_addr = pc_i + imm;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            alu_op_o     <= alu_op;
            op_32_o      <= op_32;
            op_a_o       <= op_a;
            op_b_o       <= op_b;
            rd_o         <= instr_i[11:7];
            jump_o       <= is_jal;
            jump_addr_o  <= jump_addr;
            illegal_o    <= illegal;
            misaligned_o <= is_jal & jump_addr[1];
        end
    end

endmodule

// ==== logic/execute_stage.sv ====
// Integer ALU stage
module execute_stage (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   valid_i,
    input  rv_core_pkg::alu_op_e   alu_op_i,
    input  logic                   op_32_i,
    input  rv_core_pkg::xlen_t     op_a_i,
    input  rv_core_pkg::xlen_t     op_b_i,
    input  rv_core_pkg::reg_addr_t rd_i,
    input  logic                   jump_i,
    input  rv_core_pkg::xlen_t     jump_addr_i,
    input  logic                   illegal_i,
    input  logic                   misaligned_i,
    output logic                   valid_o,
    output rv_core_pkg::xlen_t     result_o,
    output rv_core_pkg::reg_addr_t rd_o,
    output logic                   jump_o,
    output rv_core_pkg::xlen_t     jump_addr_o,
    output logic                   illegal_o,
    output logic                   misaligned_o
);

    rv_core_pkg::xlen_t res_64;
    rv_core_pkg::xlen_t result;
    logic [31:0] res_32;
    logic [31:0] word_a;
    logic [31:0] word_b;

    assign word_a = op_a_i[31:0];
    assign word_b = op_b_i[31:0];

    always_comb begin
        case (alu_op_i)
            rv_core_pkg::ALU_SUB:  res_64 = op_a_i - op_b_i;
            rv_core_pkg::ALU_SLL:  res_64 = op_a_i << op_b_i[5:0];
            rv_core_pkg::ALU_SLT:  res_64 = {63'b0, $signed(op_a_i) < $signed(op_b_i)};
            rv_core_pkg::ALU_SLTU: res_64 = {63'b0, op_a_i < op_b_i};
            rv_core_pkg::ALU_XOR:  res_64 = op_a_i ^ op_b_i;
            rv_core_pkg::ALU_SRL:  res_64 = op_a_i >> op_b_i[5:0];
            rv_core_pkg::ALU_SRA:  res_64 = $signed(op_a_i) >>> op_b_i[5:0];
            rv_core_pkg::ALU_OR:   res_64 = op_a_i | op_b_i;
            rv_core_pkg::ALU_AND:  res_64 = op_a_i & op_b_i;
            default:               res_64 = op_a_i + op_b_i;
        endcase
    end

    // word forms, shift amount is 5 bits
    always_comb begin
        case (alu_op_i)
            rv_core_pkg::ALU_SUB: res_32 = word_a - word_b;
            rv_core_pkg::ALU_SLL: res_32 = word_a << word_b[4:0];
            rv_core_pkg::ALU_SRL: res_32 = word_a >> word_b[4:0];
            rv_core_pkg::ALU_SRA: res_32 = $signed(word_a) >>> word_b[4:0];
            default:              res_32 = word_a + word_b;
        endcase
    end

    assign result = op_32_i ? {{32{res_32[31]}}, res_32} : res_64;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            result_o     <= result;
            rd_o         <= rd_i;
            jump_o       <= jump_i;
            jump_addr_o  <= jump_addr_i;
            illegal_o    <= illegal_i;
            misaligned_o <= misaligned_i;
        end
    end

endmodule

// ==== logic/result_stage.sv ====
// Result and exception stage
module result_stage (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    valid_i,
    input  rv_core_pkg::xlen_t      result_i,
    input  rv_core_pkg::reg_addr_t  rd_i,
    input  logic                    jump_i,
    input  rv_core_pkg::xlen_t      jump_addr_i,
    input  logic                    illegal_i,
    input  logic                    misaligned_i,
    output logic                    valid_o,
    output rv_core_pkg::reg_addr_t  rd_o,
    output logic                    we_o,
    output rv_core_pkg::xlen_t      result_o,
    output logic                    jump_valid_o,
    output rv_core_pkg::xlen_t      jump_addr_o,
    output logic                    exc_valid_o,
    output rv_core_pkg::exc_cause_e exc_cause_o
);

    logic fault;

    assign fault = illegal_i | misaligned_i;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_o      <= 1'b0;
            we_o         <= 1'b0;
            jump_valid_o <= 1'b0;
            exc_valid_o  <= 1'b0;
        end else begin
            valid_o      <= valid_i;
            // no write to x0 and none on a faulting instruction
            we_o         <= valid_i & ~fault & (rd_i != '0);
            jump_valid_o <= valid_i & jump_i & ~misaligned_i;
            exc_valid_o  <= valid_i & fault;
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            rd_o        <= rd_i;
            result_o    <= result_i;
            jump_addr_o <= jump_addr_i;
            // illegal wins, jal is never illegal anyway
            exc_cause_o <= illegal_i ? rv_core_pkg::EXC_ILLEGAL_INSTR
                                     : rv_core_pkg::EXC_INSTR_MISALIGNED;
        end
    end

endmodule

// ==== logic/int_pipe_top.sv ====
// Three-stage integer pipeline
module int_pipe_top (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    valid_i,
    input  rv_core_pkg::instr_t     instr_i,
    input  rv_core_pkg::xlen_t      pc_i,
    input  rv_core_pkg::xlen_t      rs1_data_i,
    input  rv_core_pkg::xlen_t      rs2_data_i,
    output logic                    valid_o,
    output rv_core_pkg::reg_addr_t  rd_o,
    output logic                    we_o,
    output rv_core_pkg::xlen_t      result_o,
    output logic                    jump_valid_o,
    output rv_core_pkg::xlen_t      jump_addr_o,
    output logic                    exc_valid_o,
    output rv_core_pkg::exc_cause_e exc_cause_o
);

    // decode to execute
    logic                   dec_valid;
    rv_core_pkg::alu_op_e   dec_alu_op;
    logic                   dec_op_32;
    rv_core_pkg::xlen_t     dec_op_a;
    rv_core_pkg::xlen_t     dec_op_b;
    rv_core_pkg::reg_addr_t dec_rd;
    logic                   dec_jump;
    rv_core_pkg::xlen_t     dec_jump_addr;
    logic                   dec_illegal;
    logic                   dec_misaligned;

    // execute to result
    logic                   ex_valid;
    rv_core_pkg::xlen_t     ex_result;
    rv_core_pkg::reg_addr_t ex_rd;
    logic                   ex_jump;
    rv_core_pkg::xlen_t     ex_jump_addr;
    logic                   ex_illegal;
    logic                   ex_misaligned;

    decode_stage decode_stage_inst (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .valid_i     (valid_i),
        .instr_i     (instr_i),
        .pc_i        (pc_i),
        .rs1_data_i  (rs1_data_i),
        .rs2_data_i  (rs2_data_i),
        .valid_o     (dec_valid),
        .alu_op_o    (dec_alu_op),
        .op_32_o     (dec_op_32),
        .op_a_o      (dec_op_a),
        .op_b_o      (dec_op_b),
        .rd_o        (dec_rd),
        .jump_o      (dec_jump),
        .jump_addr_o (dec_jump_addr),
        .illegal_o   (dec_illegal),
        .misaligned_o(dec_misaligned)
    );

    execute_stage execute_stage_inst (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .valid_i     (dec_valid),
        .alu_op_i    (dec_alu_op),
        .op_32_i     (dec_op_32),
        .op_a_i      (dec_op_a),
        .op_b_i      (dec_op_b),
        .rd_i        (dec_rd),
        .jump_i      (dec_jump),
        .jump_addr_i (dec_jump_addr),
        .illegal_i   (dec_illegal),
        .misaligned_i(dec_misaligned),
        .valid_o     (ex_valid),
        .result_o    (ex_result),
        .rd_o        (ex_rd),
        .jump_o      (ex_jump),
        .jump_addr_o (ex_jump_addr),
        .illegal_o   (ex_illegal),
        .misaligned_o(ex_misaligned)
    );

    result_stage result_stage_inst (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .valid_i     (ex_valid),
        .result_i    (ex_result),
        .rd_i        (ex_rd),
        .jump_i      (ex_jump),
        .jump_addr_i (ex_jump_addr),
        .illegal_i   (ex_illegal),
        .misaligned_i(ex_misaligned),
        .valid_o     (valid_o),
        .rd_o        (rd_o),
        .we_o        (we_o),
        .result_o    (result_o),
        .jump_valid_o(jump_valid_o),
        .jump_addr_o (jump_addr_o),
        .exc_valid_o (exc_valid_o),
        .exc_cause_o (exc_cause_o)
    );

endmodule

// ==== sim/int_pipe_properties.sv ====
// Integer pipeline output properties
module int_pipe_properties (
    input logic                   clk_i,
    input logic                   rst_n_i,
    input logic                   valid_i,
    input logic                   valid_o,
    input rv_core_pkg::reg_addr_t rd_o,
    input logic                   we_o,
    input logic                   jump_valid_o,
    input logic                   exc_valid_o
);
    timeunit 1ns;
    timeprecision 100ps;

    a_exc_exclusive: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        exc_valid_o |-> !we_o && !jump_valid_o)
        else $error("exception raised together with write or jump");

    a_we_rd_nonzero: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        we_o |-> rd_o != '0)
        else $error("write enable on x0");

    a_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        valid_i |-> ##3 valid_o)
        else $error("result missing three cycles after issue");

    a_no_spurious: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        valid_o |-> $past(valid_i, 3))
        else $error("result without matching issue");

    // skip the first edge, async reset may not have hit yet
    a_reset_quiet: assert property (@(posedge clk_i)
        !rst_n_i && $past(!rst_n_i) |-> !valid_o && !we_o && !jump_valid_o && !exc_valid_o)
        else $error("control output high during reset");

endmodule

bind int_pipe_top int_pipe_properties int_pipe_properties_inst (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .valid_i     (valid_i),
    .valid_o     (valid_o),
    .rd_o        (rd_o),
    .we_o        (we_o),
    .jump_valid_o(jump_valid_o),
    .exc_valid_o (exc_valid_o)
);

// ==== sim/int_pipe_tb.sv ====
// Integer pipeline testbench
module int_pipe_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD = 40;
    localparam int DRIVE_DLY  = 2;
    localparam int RESET_CYC  = 16;
    localparam int REC_WORDS  = 11;
    localparam int MAX_RECS   = 64;

    // one word per trace column
    localparam int F_INSTR = 0;
    localparam int F_PC    = 1;
    localparam int F_RS1   = 2;
    localparam int F_RS2   = 3;
    localparam int F_WE    = 4;
    localparam int F_RD    = 5;
    localparam int F_RES   = 6;
    localparam int F_JV    = 7;
    localparam int F_JADDR = 8;
    localparam int F_EXC   = 9;
    localparam int F_CAUSE = 10;

    logic                    clk_i;
    logic                    rst_n_i;
    logic                    valid_i;
    rv_core_pkg::instr_t     instr_i;
    rv_core_pkg::xlen_t      pc_i;
    rv_core_pkg::xlen_t      rs1_data_i;
    rv_core_pkg::xlen_t      rs2_data_i;
    logic                    valid_o;
    rv_core_pkg::reg_addr_t  rd_o;
    logic                    we_o;
    rv_core_pkg::xlen_t      result_o;
    logic                    jump_valid_o;
    rv_core_pkg::xlen_t      jump_addr_o;
    logic                    exc_valid_o;
    rv_core_pkg::exc_cause_e exc_cause_o;

    logic [63:0] trace_mem [0:MAX_RECS*REC_WORDS-1];
    int          num_recs = 0;
    logic        trace_loaded = 1'b0;
    int          cycle_cnt = 0;
    int          rec_q [$];
    int          issue_q [$];

    int_pipe_top int_pipe_top_inst (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .valid_i     (valid_i),
        .instr_i     (instr_i),
        .pc_i        (pc_i),
        .rs1_data_i  (rs1_data_i),
        .rs2_data_i  (rs2_data_i),
        .valid_o     (valid_o),
        .rd_o        (rd_o),
        .we_o        (we_o),
        .result_o    (result_o),
        .jump_valid_o(jump_valid_o),
        .jump_addr_o (jump_addr_o),
        .exc_valid_o (exc_valid_o),
        .exc_cause_o (exc_cause_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        logic fb;
        fb = state[15] ^ state[13] ^ state[12] ^ state[10];
        return {state[14:0], fb};
    endfunction

    task automatic check_value(input string field, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            $display("FAIL @ %0d ns: %s is %h, expected %h", $time, field, actual, expected);
            $display("ERRORS FOUND");
            $fatal(1, "mismatch on %s", field);
        end
    endtask

    task automatic issue_instr(input int rec);
        int base;
        base       = rec * REC_WORDS;
        valid_i    = 1'b1;
        instr_i    = trace_mem[base + F_INSTR][31:0];
        pc_i       = trace_mem[base + F_PC];
        rs1_data_i = trace_mem[base + F_RS1];
        rs2_data_i = trace_mem[base + F_RS2];
        rec_q.push_back(rec);
        issue_q.push_back(cycle_cnt);
    endtask

    task automatic check_result();
        int rec;
        int issued;
        int base;
        if (rec_q.size() == 0) begin
            $display("valid_o went high at %0d ns with no instruction outstanding", $time);
            $display("ERRORS FOUND");
            $fatal(1, "unexpected result");
        end
        rec    = rec_q.pop_front();
        issued = issue_q.pop_front();
        base   = rec * REC_WORDS;
        check_value("latency", cycle_cnt - issued, 64'd3);
        check_value("we_o", we_o, trace_mem[base + F_WE]);
        check_value("rd_o", rd_o, trace_mem[base + F_RD]);
        check_value("jump_valid_o", jump_valid_o, trace_mem[base + F_JV]);
        check_value("exc_valid_o", exc_valid_o, trace_mem[base + F_EXC]);
        check_value("exc_cause_o", exc_cause_o, trace_mem[base + F_CAUSE]);
        check_value("result_o", result_o, trace_mem[base + F_RES]);
        if (trace_mem[base + F_JV][0]) begin
            check_value("jump_addr_o", jump_addr_o, trace_mem[base + F_JADDR]);
        end
    endtask

    // outputs settle after the rising edge
    always @(negedge clk_i) begin
        if (rst_n_i === 1'b1 && valid_o === 1'b1) begin
            check_result();
        end
    end

    initial begin : watchdog
        wait (trace_loaded);
        repeat (RESET_CYC + 2 * num_recs + 10) @(posedge clk_i);
        $display("timeout: pipeline stalled with %0d results outstanding", rec_q.size());
        $display("ERRORS FOUND");
        $fatal(1, "watchdog expired");
    end

    initial begin
        logic [15:0] lfsr;
        int          rec;
        rst_n_i    = 1'b0;
        valid_i    = 1'b0;
        instr_i    = '0;
        pc_i       = '0;
        rs1_data_i = '0;
        rs2_data_i = '0;
        lfsr       = 16'd17200;

        // unused records keep a nonzero upper instr word
        for (int i = 0; i < MAX_RECS * REC_WORDS; i++) begin
            trace_mem[i] = {~32'(i), 32'(i)};
        end
        $readmemh("sim/int_pipe_trace.txt", trace_mem);
        while (num_recs < MAX_RECS && trace_mem[num_recs * REC_WORDS][63:32] == 32'h0) begin
            num_recs++;
        end
        if (num_recs == 0) begin
            $display("trace file sim/int_pipe_trace.txt is missing or empty");
            $display("ERRORS FOUND");
            $fatal(1, "no stimulus");
        end
        trace_loaded = 1'b1;

        repeat (RESET_CYC) @(posedge clk_i);
        #DRIVE_DLY;
        rst_n_i = 1'b1;

        for (rec = 0; rec < num_recs; rec++) begin
            lfsr = lfsr_next(lfsr);
            if (lfsr[0]) begin
                @(posedge clk_i);
                #DRIVE_DLY;
                valid_i = 1'b0;
            end
            @(posedge clk_i);
            #DRIVE_DLY;
            issue_instr(rec);
        end
        @(posedge clk_i);
        #DRIVE_DLY;
        valid_i = 1'b0;

        while (rec_q.size() != 0) begin
            @(posedge clk_i);
        end
        @(posedge clk_i);
        $display("NO ERRORS");
        $finish;
    end

endmodule

// ==== sources.f ====
logic/rv_core_pkg.sv
logic/imm_gen.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/result_stage.sv
logic/int_pipe_top.sv
sim/int_pipe_properties.sv
sim/int_pipe_tb.sv

// ==== Bender.yml ====
package:
  name: int_pipe

sources:
  - logic/rv_core_pkg.sv
  - logic/imm_gen.sv
  - logic/decode_stage.sv
  - logic/execute_stage.sv
  - logic/result_stage.sv
  - logic/int_pipe_top.sv
  - target: simulation
    files:
      - sim/int_pipe_properties.sv
      - sim/int_pipe_tb.sv

// ==== sim/int_pipe_trace.txt ====
// instr pc rs1_data rs2_data | we rd result jump_valid jump_addr exc_valid cause
// one instruction per line, all hex
002081b3 0 7fffffffffffffff 1 1 3 8000000000000000 0 0 0 0
40208233 0 5 7 1 4 fffffffffffffffe 0 0 0 0
0020a2b3 0 ffffffffffffffff 1 1 5 1 0 0 0 0
0020b333 0 ffffffffffffffff 1 1 6 0 0 0 0 0
4020d3b3 0 8000000000000000 44 1 7 f800000000000000 0 0 0 0
00209433 0 1 3f 1 8 8000000000000000 0 0 0 0
0020c4b3 0 f0f0f0f0f0f0f0f0 ff00ff00ff00ff00 1 9 0ff00ff00ff00ff0 0 0 0 0
fff08513 0 0 0 1 a ffffffffffffffff 0 0 0 0
0f00f613 0 123456789abcdef0 0 1 c f0 0 0 0 0
8000e693 0 5 0 1 d fffffffffffff805 0 0 0 0
4210d713 0 8000000000000000 0 1 e ffffffffc0000000 0 0 0 0
03c0d793 0 f000000000000000 0 1 f f 0 0 0 0
0010881b 0 7fffffff 0 1 10 ffffffff80000000 0 0 0 0
4020d8bb 0 1234567880000000 4 1 11 fffffffff8000000 0 0 0 0
0020d93b 0 ffffffff80000000 24 1 12 8000000 0 0 0 0
80000ab7 0 1234 0 1 15 ffffffff80000000 0 0 0 0
12345b17 1000 0 0 1 16 12346000 0 0 0 0
100000ef 2000 0 0 1 1 2004 1 2100 0 0
ffdff06f 3000 0 0 0 0 3004 1 2ffc 0 0
006002ef 4000 0 0 0 5 4004 0 4006 1 0
0000b303 0 0 0 0 6 0 0 0 1 2
4020c3b3 0 0 0 0 7 0 0 0 1 2
40109413 0 0 0 0 8 0 0 0 1 2
00208033 0 1 2 0 0 3 0 0 0 0
